// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ipt_mmu
FILELIST = sources.f
OBJ_DIR  = obj_dir
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_ipt_mmu.sv
// ==============================
// testbench for the inverted page table MMU
// APB driver, translation driver, reference
// model of the hash chain and checking by
// concurrent assertions
// ==============================

module tb_ipt_mmu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 8;
	localparam int SEED         = 49875;
	localparam int N_TESTS      = 6;
	localparam int OPS_PER_TEST = 48;
	localparam int WALK_BOUND   = 2 * ipt_pkg::IPT_MAX_PROBES + 2;
	localparam int WATCHDOG_CYCLES = 4 + ipt_pkg::IPT_ENTRIES +
		N_TESTS * OPS_PER_TEST * (WALK_BOUND + 8);

	logic clk = 1'b0;
	logic rst;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	logic [3:0] paddr_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic pready_o;
	logic req_valid_i;
	logic req_ready_o;
	logic priv_i;
	logic [7:0] asid_i;
	logic [31:0] vadr_i;
	logic we_i;
	logic exec_i;
	logic resp_valid_o;
	logic [22:0] padr_o;
	logic fault_o;
	logic rdv_o;
	logic wrv_o;
	logic exv_o;

	// expected response and read data that the drivers set up
	logic [22:0] exp_padr;
	logic exp_fault;
	logic exp_rdv;
	logic exp_wrv;
	logic exp_exv;
	logic rd_check;
	logic [31:0] rd_exp;
	logic [7:0] walk_cycles;

	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// reference model indexed by the {asid, vpn} key
	logic [9:0] ref_slot [logic [26:0]];
	logic [3:0] ref_drwx [logic [26:0]];
	logic [26:0] slot_key [ipt_pkg::IPT_ENTRIES];
	logic slot_used [ipt_pkg::IPT_ENTRIES];

	ipt_mmu_top DUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic void report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("FAIL %s got 0x%0h expected 0x%0h", sig, got, exp);
	endfunction

	function automatic void report_error(input string msg);
		errors++;
		$display("error: %s", msg);
	endfunction

	// ==============================
	// checks
	// ==============================

	always @(posedge clk) begin
		if (rst || resp_valid_o)
			walk_cycles <= '0;
		else if (req_valid_i && req_ready_o)
			walk_cycles <= 8'd1;
		else if (walk_cycles != '0)
			walk_cycles <= walk_cycles + 8'd1;
	end

	reset_quiet: assert property (@(posedge clk)
		rst |=> !req_ready_o && !resp_valid_o && !pready_o && !DUT.cmd_bus.done)
		else report_error("outputs not quiet after reset");
	sweep_stall: assert property (@(posedge clk) disable iff (rst)
		DUT.init_busy |-> !req_ready_o && !pready_o)
		else report_error("port ready during the table sweep");
	bypass_latency: assert property (@(posedge clk) disable iff (rst)
		req_valid_i && req_ready_o && priv_i |=> resp_valid_o)
		else report_error("bypass response did not follow acceptance by one cycle");
	walk_latency: assert property (@(posedge clk) disable iff (rst)
		walk_cycles <= 8'(WALK_BOUND))
		else report_error("translation took longer than the walk bound");
	padr_ok: assert property (@(posedge clk) disable iff (rst)
		resp_valid_o |-> padr_o == exp_padr)
		else report_mismatch("padr_o", 32'($sampled(padr_o)), 32'($sampled(exp_padr)));
	fault_ok: assert property (@(posedge clk) disable iff (rst)
		resp_valid_o |-> fault_o == exp_fault)
		else report_mismatch("fault_o", 32'($sampled(fault_o)), 32'($sampled(exp_fault)));
	rdv_ok: assert property (@(posedge clk) disable iff (rst)
		resp_valid_o |-> rdv_o == exp_rdv)
		else report_mismatch("rdv_o", 32'($sampled(rdv_o)), 32'($sampled(exp_rdv)));
	wrv_ok: assert property (@(posedge clk) disable iff (rst)
		resp_valid_o |-> wrv_o == exp_wrv)
		else report_mismatch("wrv_o", 32'($sampled(wrv_o)), 32'($sampled(exp_wrv)));
	exv_ok: assert property (@(posedge clk) disable iff (rst)
		resp_valid_o |-> exv_o == exp_exv)
		else report_mismatch("exv_o", 32'($sampled(exv_o)), 32'($sampled(exp_exv)));
	prdata_ok: assert property (@(posedge clk) disable iff (rst)
		rd_check && psel_i && penable_i && pready_o && !pwrite_i |-> prdata_o == rd_exp)
		else report_mismatch("prdata_o", $sampled(prdata_o), $sampled(rd_exp));

	// ==============================
	// reference model
	// ==============================

	function automatic logic [9:0] chain_slot(input logic [7:0] asid, input logic [18:0] vpn,
		input int k);
		logic [9:0] base;
		base = {1'b0, asid[2:0], vpn[5:0]};
		if (k == 0)
			return base;
		return base + 10'd512 + 10'(ipt_pkg::IPT_STEP * (k - 1));
	endfunction

	// first slot in the chain that holds the key or is empty
	function automatic logic model_place(input logic [7:0] asid, input logic [18:0] vpn,
		output logic [9:0] slot);
		for (int k = 0; k < ipt_pkg::IPT_MAX_PROBES; k++) begin
			slot = chain_slot(asid, vpn, k);
			if (!slot_used[slot] || slot_key[slot] == {asid, vpn})
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// ==============================
	// drivers
	// ==============================

	task automatic apb_write(input logic [1:0] word, input logic [31:0] data);
		@(posedge clk);
		psel_i <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i <= 1'b1;
		paddr_i <= {word, 2'b00};
		pwdata_i <= data;
		@(posedge clk);
		penable_i <= 1'b1;
		@(negedge clk);
		while (!pready_o)
			@(negedge clk);
		@(posedge clk);
		psel_i <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic apb_read(input logic [1:0] word, input logic [31:0] exp);
		@(posedge clk);
		psel_i <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i <= 1'b0;
		paddr_i <= {word, 2'b00};
		rd_exp <= exp;
		rd_check <= 1'b1;
		@(posedge clk);
		penable_i <= 1'b1;
		@(negedge clk);
		while (!pready_o)
			@(negedge clk);
		@(posedge clk);
		psel_i <= 1'b0;
		penable_i <= 1'b0;
		rd_check <= 1'b0;
	endtask

	task automatic update_entry(input logic [7:0] asid, input logic [18:0] vpn,
		input logic [3:0] drwx);
		logic [9:0] slot;
		logic found;
		logic [31:0] stat;
		found = model_place(asid, vpn, slot);
		stat = '0;
		stat[ipt_pkg::STAT_FOUND_BIT] = found;
		apb_write(ipt_pkg::REG_PTE, {asid, 1'b0, vpn, drwx});
		apb_write(ipt_pkg::REG_CMD, 32'(ipt_pkg::CMD_UPDATE));
		apb_read(ipt_pkg::REG_STAT, stat);
		if (found) begin
			apb_read(ipt_pkg::REG_SLOT, 32'(slot));
			slot_used[slot] = 1'b1;
			slot_key[slot] = {asid, vpn};
			ref_slot[{asid, vpn}] = slot;
			ref_drwx[{asid, vpn}] = drwx;
		end
	endtask

	task automatic probe_entry(input logic [7:0] asid, input logic [18:0] vpn);
		logic found;
		logic [31:0] stat;
		found = (ref_slot.exists({asid, vpn}) != 0);
		stat = '0;
		stat[ipt_pkg::STAT_FOUND_BIT] = found;
		apb_write(ipt_pkg::REG_PTE, {asid, 1'b0, vpn, 4'b0000});
		apb_write(ipt_pkg::REG_CMD, 32'(ipt_pkg::CMD_PROBE));
		apb_read(ipt_pkg::REG_STAT, stat);
		if (found) begin
			apb_read(ipt_pkg::REG_SLOT, 32'(ref_slot[{asid, vpn}]));
			apb_read(ipt_pkg::REG_PTE, {asid, 1'b0, vpn, ref_drwx[{asid, vpn}]});
		end
	endtask

	task automatic translate(input logic priv, input logic [7:0] asid, input logic [31:0] vadr,
		input logic we, input logic exec);
		logic [3:0] perm;
		exp_padr = '0;
		exp_fault = 1'b0;
		exp_rdv = 1'b0;
		exp_wrv = 1'b0;
		exp_exv = 1'b0;
		if (priv) begin
			exp_padr = vadr[22:0];
		end else if (ref_slot.exists({asid, vadr[31:13]}) != 0) begin
			perm = ref_drwx[{asid, vadr[31:13]}];
			exp_padr = {ref_slot[{asid, vadr[31:13]}], vadr[12:0]};
			// any access that is not a write needs the read bit
			exp_rdv = !we && !perm[2];
			exp_wrv = we && !perm[1];
			exp_exv = exec && !perm[0];
		end else begin
			exp_fault = 1'b1;
		end
		@(posedge clk);
		req_valid_i <= 1'b1;
		priv_i <= priv;
		asid_i <= asid;
		vadr_i <= vadr;
		we_i <= we;
		exec_i <= exec;
		@(negedge clk);
		while (!req_ready_o)
			@(negedge clk);
		@(posedge clk);
		req_valid_i <= 1'b0;
		@(negedge clk);
		while (!resp_valid_o)
			@(negedge clk);
		// the response is compared at the edge that closes its cycle
		@(posedge clk);
	endtask

	task automatic finish_test(input string name);
		repeat (2) @(posedge clk);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		logic [7:0] a2;
		logic [18:0] v2;
		logic [7:0] a3;
		logic [18:0] v3a;
		logic [18:0] v3b;
		logic [7:0] a6;
		logic [5:0] low6;
		void'($urandom(SEED));
		rst = 1'b1;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		req_valid_i = 1'b0;
		priv_i = 1'b0;
		asid_i = '0;
		vadr_i = '0;
		we_i = 1'b0;
		exec_i = 1'b0;
		rd_check = 1'b0;
		rd_exp = '0;
		for (int i = 0; i < ipt_pkg::IPT_ENTRIES; i++)
			slot_used[i] = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// empty table after the sweep
		for (int i = 0; i < 3; i++)
			translate(1'b0, 8'($urandom), $urandom, 1'b0, 1'b0);
		probe_entry(8'($urandom), 19'($urandom));
		finish_test("empty table");

		a2 = {5'($urandom), 3'd1};
		v2 = 19'($urandom);
		update_entry(a2, v2, 4'b0111);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b0, 1'b0);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b1, 1'b0);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b0, 1'b1);
		finish_test("update then translate");

		// same low bits of asid and vpn, so both start in one primary slot
		a3 = {5'($urandom), 3'd2};
		v3a = 19'($urandom);
		v3b = {v3a[18:6] ^ 13'h1a5, v3a[5:0]};
		update_entry(a3, v3a, 4'b0110);
		update_entry(a3, v3b, 4'b0101);
		probe_entry(a3, v3a);
		probe_entry(a3, v3b);
		translate(1'b0, a3, {v3b, 13'($urandom)}, 1'b0, 1'b1);
		finish_test("primary collision");

		update_entry(a2, v2, 4'b0101);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b1, 1'b0);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b0, 1'b0);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b0, 1'b1);
		update_entry(a2, v2, 4'b0100);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b0, 1'b1);
		// without the read bit a plain load is refused
		update_entry(a2, v2, 4'b0011);
		translate(1'b0, a2, {v2, 13'($urandom)}, 1'b0, 1'b0);
		probe_entry(a2, v2);
		finish_test("permission change");

		translate(1'b1, a2, {v2, 13'($urandom)}, 1'b1, 1'b0);
		for (int i = 0; i < 3; i++)
			translate(1'b1, 8'($urandom), $urandom, 1'($urandom), 1'($urandom));
		finish_test("machine mode bypass");

		a6 = {5'($urandom), 3'd5};
		low6 = 6'($urandom);
		for (int k = 0; k <= ipt_pkg::IPT_MAX_PROBES; k++)
			update_entry(a6, {13'(k * 97 + 3), low6}, 4'b0110);
		probe_entry(a6, {13'(ipt_pkg::IPT_MAX_PROBES * 97 + 3), low6});
		finish_test("full chain");

		$display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// ends a run that stalls on a handshake
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: no progress after %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: sources.f
src/ipt_pkg.sv
src/ipt_if.sv
src/ipt_table_ram.sv
src/ipt_probe_seq.sv
src/ipt_apb_regs.sv
src/ipt_access_check.sv
src/ipt_walk_ctrl.sv
src/ipt_mmu_top.sv
dv/tb_ipt_mmu.sv

// File: src/ipt_access_check.sv
// ==============================
// permission check
// physical address and read, write and
// execute violations for a matched PTE
// ==============================

module ipt_access_check (
	input  ipt_pkg::pte_t                  pte_i,
	input  logic [ipt_pkg::IPT_IDX_W-1:0]  slot_i,
	input  logic [ipt_pkg::IPT_OFS_W-1:0]  offset_i,
	input  logic                           we_i,
	input  logic                           exec_i,
	output logic                           rdv_o,
	output logic                           wrv_o,
	output logic                           exv_o,
	output logic [ipt_pkg::IPT_PA_W-1:0]   padr_o
);

	logic perm_r;
	logic perm_w;
	logic perm_x;

	assign perm_r = pte_i.drwx[2];
	assign perm_w = pte_i.drwx[1];
	assign perm_x = pte_i.drwx[0];

	// the frame number is the slot itself
	assign padr_o = {slot_i, offset_i};

	// an instruction fetch is also a read
	assign rdv_o = ~we_i & ~perm_r;
	assign wrv_o = we_i & ~perm_w;
	assign exv_o = exec_i & ~perm_x;

endmodule

// File: src/ipt_apb_regs.sv
// ==============================
// APB register slave
// staged PTE, command issue with wait
// states and the probe result registers
// ==============================

module ipt_apb_regs (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           psel_i,
	input  logic                           penable_i,
	input  logic                           pwrite_i,
	input  logic [ipt_pkg::IPT_APB_AW-1:0] paddr_i,
	input  logic [ipt_pkg::IPT_APB_DW-1:0] pwdata_i,
	output logic [ipt_pkg::IPT_APB_DW-1:0] prdata_o,
	output logic                           pready_o,
	ipt_cmd_if.regs                        cmd
);

	logic [1:0]                    word;
	logic                          access;
	logic                          cmd_wr;
	logic                          cmd_ok;
	logic                          pend;
	logic                          init_done;
	logic                          found_q;
	logic [ipt_pkg::IPT_IDX_W-1:0] slot_q;
	ipt_pkg::pte_t                 stage;

	assign word   = paddr_i[3:2];
	assign access = psel_i & penable_i;
	assign cmd_ok = (pwdata_i[1:0] == ipt_pkg::CMD_UPDATE) |
		(pwdata_i[1:0] == ipt_pkg::CMD_PROBE);
	assign cmd_wr = access & pwrite_i & (word == ipt_pkg::REG_CMD) & cmd_ok;

	// go fires once per command write, the walker is idle by then
	assign cmd.go  = cmd_wr & ~pend & ~cmd.busy & init_done;
	assign cmd.cmd = ipt_pkg::cmd_e'(pwdata_i[1:0]);
	assign cmd.pte = stage;

	// a command write waits for done, everything else only for the sweep
	assign pready_o = cmd_wr ? (pend & cmd.done) : init_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			init_done <= 1'b0;
			found_q <= 1'b0;
			slot_q <= '0;
			stage <= '0;
		end else begin
			if (!cmd.busy)
				init_done <= 1'b1;
			if (cmd.go)
				pend <= 1'b1;
			else if (cmd.done)
				pend <= 1'b0;
			if (cmd.done) begin
				found_q <= cmd.found;
				slot_q <= cmd.slot;
			end
			// a successful command reports back the entry it found or wrote
			if (cmd.done && cmd.found)
				stage <= cmd.res_pte;
			else if (access && pwrite_i && init_done && word == ipt_pkg::REG_PTE)
				stage <= pwdata_i;
		end
	end

	always_comb begin
		prdata_o = '0;
		case (word)
			ipt_pkg::REG_SLOT: prdata_o[ipt_pkg::IPT_IDX_W-1:0] = slot_q;
			ipt_pkg::REG_PTE:  prdata_o = stage;
			ipt_pkg::REG_STAT: begin
				prdata_o[ipt_pkg::STAT_FOUND_BIT] = found_q;
				prdata_o[ipt_pkg::STAT_BUSY_BIT] = cmd.busy;
			end
			default: prdata_o = '0;
		endcase
	end

endmodule

// File: src/ipt_if.sv
// ==============================
// table port and command exchange
// between the registers and the walker
// ==============================

interface ipt_tbl_if;
	logic [ipt_pkg::IPT_IDX_W-1:0] addr;
	logic                          we;
	ipt_pkg::pte_t                 wdata;
	// valid one cycle after addr
	ipt_pkg::pte_t                 rdata;

	modport ctrl (output addr, we, wdata, input rdata);
	modport mem  (input addr, we, wdata, output rdata);
endinterface

interface ipt_cmd_if;
	ipt_pkg::cmd_e                 cmd;
	logic                          go;
	ipt_pkg::pte_t                 pte;
	logic                          busy;
	logic                          done;
	logic                          found;
	logic [ipt_pkg::IPT_IDX_W-1:0] slot;
	ipt_pkg::pte_t                 res_pte;

	modport regs (output cmd, go, pte, input busy, done, found, slot, res_pte);
	modport walk (input cmd, go, pte, output busy, done, found, slot, res_pte);
endinterface

// File: src/ipt_mmu_top.sv
// ==============================
// inverted page table MMU
// APB register port and a valid/ready
// translation port
// ==============================

module ipt_mmu_top (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           psel_i,
	input  logic                           penable_i,
	input  logic                           pwrite_i,
	input  logic [ipt_pkg::IPT_APB_AW-1:0] paddr_i,
	input  logic [ipt_pkg::IPT_APB_DW-1:0] pwdata_i,
	output logic [ipt_pkg::IPT_APB_DW-1:0] prdata_o,
	output logic                           pready_o,
	input  logic                           req_valid_i,
	output logic                           req_ready_o,
	input  logic                           priv_i,
	input  logic [ipt_pkg::IPT_ASID_W-1:0] asid_i,
	input  logic [31:0]                    vadr_i,
	input  logic                           we_i,
	input  logic                           exec_i,
	output logic                           resp_valid_o,
	output logic [ipt_pkg::IPT_PA_W-1:0]   padr_o,
	output logic                           fault_o,
	output logic                           rdv_o,
	output logic                           wrv_o,
	output logic                           exv_o
);

	logic                           init_busy;
	logic                           seq_load;
	logic                           seq_next;
	logic [ipt_pkg::IPT_ASID_W-1:0] seq_asid;
	logic [ipt_pkg::IPT_VPN_W-1:0]  seq_vpn;
	logic [ipt_pkg::IPT_IDX_W-1:0]  seq_slot;
	logic                           seq_exhausted;
	logic [ipt_pkg::IPT_OFS_W-1:0]  chk_ofs;
	logic                           chk_we;
	logic                           chk_exec;
	logic [ipt_pkg::IPT_PA_W-1:0]   chk_padr;
	logic                           chk_rdv;
	logic                           chk_wrv;
	logic                           chk_exv;

	ipt_tbl_if tbl_bus ();
	ipt_cmd_if cmd_bus ();

	ipt_table_ram u_ram (
		.clk(clk), .rst(rst), .tbl(tbl_bus.mem), .init_busy_o(init_busy)
	);

	ipt_probe_seq u_seq (
		.clk(clk), .rst(rst), .load_i(seq_load), .next_i(seq_next),
		.asid_i(seq_asid), .vpn_i(seq_vpn), .slot_o(seq_slot),
		.exhausted_o(seq_exhausted)
	);

	ipt_apb_regs u_regs (
		.clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i),
		.pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.prdata_o(prdata_o), .pready_o(pready_o), .cmd(cmd_bus.regs)
	);

	// the check looks at the entry being compared in the current slot
	ipt_access_check u_chk (
		.pte_i(tbl_bus.rdata), .slot_i(seq_slot), .offset_i(chk_ofs),
		.we_i(chk_we), .exec_i(chk_exec), .rdv_o(chk_rdv), .wrv_o(chk_wrv),
		.exv_o(chk_exv), .padr_o(chk_padr)
	);

	ipt_walk_ctrl u_walk (
		.clk(clk), .rst(rst), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
		.priv_i(priv_i), .asid_i(asid_i), .vadr_i(vadr_i), .we_i(we_i),
		.exec_i(exec_i), .init_busy_i(init_busy), .tbl(tbl_bus.ctrl),
		.cmd(cmd_bus.walk), .seq_load_o(seq_load), .seq_next_o(seq_next),
		.seq_asid_o(seq_asid), .seq_vpn_o(seq_vpn), .seq_slot_i(seq_slot),
		.seq_exhausted_i(seq_exhausted), .chk_ofs_o(chk_ofs), .chk_we_o(chk_we),
		.chk_exec_o(chk_exec), .chk_padr_i(chk_padr), .chk_rdv_i(chk_rdv),
		.chk_wrv_i(chk_wrv), .chk_exv_i(chk_exv), .resp_valid_o(resp_valid_o),
		.padr_o(padr_o), .fault_o(fault_o), .rdv_o(rdv_o), .wrv_o(wrv_o),
		.exv_o(exv_o)
	);

endmodule

// File: src/ipt_pkg.sv
// ==============================
// inverted page table MMU package
// table geometry, PTE layout, hash rule,
// register offsets and command codes
// ==============================

package ipt_pkg;

	// table geometry
	localparam int IPT_IDX_W      = 10;
	localparam int IPT_ENTRIES    = 1 << IPT_IDX_W;
	localparam int IPT_OFS_W      = 13;
	localparam int IPT_VPN_W      = 19;
	localparam int IPT_ASID_W     = 8;
	localparam int IPT_PA_W       = IPT_IDX_W + IPT_OFS_W;
	localparam int IPT_STEP       = 65;
	localparam int IPT_MAX_PROBES = 8;
	localparam int IPT_CNT_W      = $clog2(IPT_MAX_PROBES + 1);

	// APB register port, word offsets sit in paddr[3:2]
	localparam int IPT_APB_AW = 4;
	localparam int IPT_APB_DW = 32;

	localparam logic [1:0] REG_CMD  = 2'd0;
	localparam logic [1:0] REG_SLOT = 2'd1;
	localparam logic [1:0] REG_PTE  = 2'd2;
	localparam logic [1:0] REG_STAT = 2'd3;

	localparam int STAT_FOUND_BIT = 0;
	localparam int STAT_BUSY_BIT  = 1;

	// drwx holds dirty, read, write, execute from the top
	typedef struct packed {
		logic [IPT_ASID_W-1:0] asid;
		logic                  last;
		logic [IPT_VPN_W-1:0]  vpn;
		logic [3:0]            drwx;
	} pte_t;

	typedef enum logic [1:0] {
		CMD_NONE   = 2'd0,
		CMD_UPDATE = 2'd1,
		CMD_PROBE  = 2'd2
	} cmd_e;

	// sec selects the secondary slot, later probes step from there
	function automatic logic [IPT_IDX_W-1:0] ipt_hash(input logic [IPT_ASID_W-1:0] asid,
		input logic [IPT_VPN_W-1:0] vpn, input logic sec);
		return {sec, asid[2:0], vpn[5:0]};
	endfunction

endpackage

// File: src/ipt_probe_seq.sv
// ==============================
// probe slot sequencer
// primary hash, secondary hash, then
// steps of IPT_STEP modulo the table size
// ==============================

module ipt_probe_seq (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             load_i,
	input  logic                             next_i,
	input  logic [ipt_pkg::IPT_ASID_W-1:0]   asid_i,
	input  logic [ipt_pkg::IPT_VPN_W-1:0]    vpn_i,
	output logic [ipt_pkg::IPT_IDX_W-1:0]    slot_o,
	output logic                             exhausted_o
);

	logic [ipt_pkg::IPT_CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_o <= '0;
			cnt <= '0;
		end else if (load_i) begin
			slot_o <= ipt_pkg::ipt_hash(asid_i, vpn_i, 1'b0);
			cnt <= ipt_pkg::IPT_CNT_W'(1);
		end else if (next_i && !exhausted_o) begin
			cnt <= cnt + 1'b1;
			// the primary slot always has a zero top bit
			if (cnt == ipt_pkg::IPT_CNT_W'(1))
				slot_o <= {1'b1, slot_o[ipt_pkg::IPT_IDX_W-2:0]};
			else
				slot_o <= slot_o + ipt_pkg::IPT_IDX_W'(ipt_pkg::IPT_STEP);
		end
	end

	assign exhausted_o = (cnt == ipt_pkg::IPT_CNT_W'(ipt_pkg::IPT_MAX_PROBES));

endmodule

// File: src/ipt_table_ram.sv
// ==============================
// page table memory
// single port, one cycle read, zeroed
// by a sweep after reset
// ==============================

module ipt_table_ram (
	input  logic     clk,
	input  logic     rst,
	ipt_tbl_if.mem   tbl,
	output logic     init_busy_o
);

	ipt_pkg::pte_t                 mem [ipt_pkg::IPT_ENTRIES];
	logic [ipt_pkg::IPT_IDX_W-1:0] clr_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			init_busy_o <= 1'b1;
			clr_cnt <= '0;
		end else if (init_busy_o) begin
			clr_cnt <= clr_cnt + 1'b1;
			if (clr_cnt == ipt_pkg::IPT_IDX_W'(ipt_pkg::IPT_ENTRIES - 1))
				init_busy_o <= 1'b0;
		end
	end

	// the sweep owns the write port until it has visited every slot
	always_ff @(posedge clk) begin
		if (init_busy_o)
			mem[clr_cnt] <= '0;
		else if (tbl.we)
			mem[tbl.addr] <= tbl.wdata;
		tbl.rdata <= mem[tbl.addr];
	end

endmodule

// File: src/ipt_walk_ctrl.sv
// ==============================
// table walk controller
// serves translations and commands,
// probes slot by slot, writes entries
// ==============================

module ipt_walk_ctrl (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            req_valid_i,
	output logic                            req_ready_o,
	input  logic                            priv_i,
	input  logic [ipt_pkg::IPT_ASID_W-1:0]  asid_i,
	input  logic [31:0]                     vadr_i,
	input  logic                            we_i,
	input  logic                            exec_i,
	input  logic                            init_busy_i,
	ipt_tbl_if.ctrl                         tbl,
	ipt_cmd_if.walk                         cmd,
	output logic                            seq_load_o,
	output logic                            seq_next_o,
	output logic [ipt_pkg::IPT_ASID_W-1:0]  seq_asid_o,
	output logic [ipt_pkg::IPT_VPN_W-1:0]   seq_vpn_o,
	input  logic [ipt_pkg::IPT_IDX_W-1:0]   seq_slot_i,
	input  logic                            seq_exhausted_i,
	output logic [ipt_pkg::IPT_OFS_W-1:0]   chk_ofs_o,
	output logic                            chk_we_o,
	output logic                            chk_exec_o,
	input  logic [ipt_pkg::IPT_PA_W-1:0]    chk_padr_i,
	input  logic                            chk_rdv_i,
	input  logic                            chk_wrv_i,
	input  logic                            chk_exv_i,
	output logic                            resp_valid_o,
	output logic [ipt_pkg::IPT_PA_W-1:0]    padr_o,
	output logic                            fault_o,
	output logic                            rdv_o,
	output logic                            wrv_o,
	output logic                            exv_o
);

	typedef enum logic [2:0] {
		ST_INIT, ST_IDLE, ST_READ, ST_CMP, ST_WRITE, ST_RESP
	} state_e;

	state_e                         state;
	ipt_pkg::cmd_e                  op;
	logic                           accept;
	logic                           hit;
	logic                           empty;
	logic [ipt_pkg::IPT_ASID_W-1:0] key_asid;
	logic [ipt_pkg::IPT_VPN_W-1:0]  key_vpn;
	ipt_pkg::pte_t                  stage;

	// ============================
	// handshakes and table port
	// ============================

	assign req_ready_o = (state == ST_IDLE) & ~cmd.go;
	assign accept      = req_valid_i & req_ready_o;
	assign cmd.busy    = (state != ST_IDLE);
	assign cmd.done    = (state == ST_RESP) & (op != ipt_pkg::CMD_NONE);
	assign resp_valid_o = (state == ST_RESP) & (op == ipt_pkg::CMD_NONE);

	assign seq_asid_o = cmd.go ? cmd.pte.asid : asid_i;
	assign seq_vpn_o  = cmd.go ? cmd.pte.vpn : vadr_i[31:13];
	assign seq_load_o = cmd.go | (accept & ~priv_i);
	assign seq_next_o = (state == ST_CMP) & ~hit & ~empty & ~seq_exhausted_i;

	assign tbl.addr  = seq_slot_i;
	assign tbl.we    = (state == ST_WRITE);
	assign tbl.wdata = stage;

	assign empty = (tbl.rdata.drwx[2:0] == 3'b000);
	assign hit   = ~empty & (tbl.rdata.asid == key_asid) & (tbl.rdata.vpn == key_vpn);

	// request payload, held for the whole walk
	always_ff @(posedge clk) begin
		if (cmd.go) begin
			key_asid <= cmd.pte.asid;
			key_vpn <= cmd.pte.vpn;
			stage <= cmd.pte;
		end else if (accept) begin
			key_asid <= asid_i;
			key_vpn <= vadr_i[31:13];
			chk_ofs_o <= vadr_i[ipt_pkg::IPT_OFS_W-1:0];
			chk_we_o <= we_i;
			chk_exec_o <= exec_i;
		end
	end

	// ============================
	// walk FSM
	// ============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_INIT;
			op <= ipt_pkg::CMD_NONE;
			cmd.found <= 1'b0;
			cmd.slot <= '0;
			cmd.res_pte <= '0;
			padr_o <= '0;
			fault_o <= 1'b0;
			rdv_o <= 1'b0;
			wrv_o <= 1'b0;
			exv_o <= 1'b0;
		end else begin
			case (state)
				ST_INIT: if (!init_busy_i) state <= ST_IDLE;
				ST_IDLE: begin
					if (cmd.go) begin
						op <= cmd.cmd;
						state <= ST_READ;
					end else if (accept) begin
						op <= ipt_pkg::CMD_NONE;
						if (priv_i) begin
							// machine mode goes straight through
							padr_o <= vadr_i[ipt_pkg::IPT_PA_W-1:0];
							fault_o <= 1'b0;
							rdv_o <= 1'b0;
							wrv_o <= 1'b0;
							exv_o <= 1'b0;
							state <= ST_RESP;
						end else begin
							state <= ST_READ;
						end
					end
				end
				ST_READ: state <= ST_CMP;
				ST_CMP: begin
					if (hit || empty || seq_exhausted_i) begin
						state <= ST_RESP;
						cmd.slot <= seq_slot_i;
						case (op)
							ipt_pkg::CMD_UPDATE: begin
								cmd.found <= hit | empty;
								cmd.res_pte <= (hit | empty) ? stage : '0;
								if (hit || empty)
									state <= ST_WRITE;
							end
							ipt_pkg::CMD_PROBE: begin
								cmd.found <= hit;
								cmd.res_pte <= hit ? tbl.rdata : '0;
							end
							default: begin
								padr_o <= hit ? chk_padr_i : '0;
								fault_o <= ~hit;
								rdv_o <= hit & chk_rdv_i;
								wrv_o <= hit & chk_wrv_i;
								exv_o <= hit & chk_exv_i;
							end
						endcase
					end else begin
						state <= ST_READ;
					end
				end
				ST_WRITE: state <= ST_RESP;
				ST_RESP:  state <= ST_IDLE;
				default:  state <= ST_INIT;
			endcase
		end
	end

endmodule
